// ==== tomasulo_isa_pkg.sv ====
package tomasulo_isa_pkg;

    localparam int DATA_W = 16;
    localparam int BYTE_W = 8;
    localparam int REG_W  = 4;

    // Opcodes 6 to 15 are illegal.
    typedef enum logic [3:0]
    {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_MUL = 4'd4,
        OP_DIV = 4'd5
    } op_e;

    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BYTE_W-1:0] byte_t;

    // Host instruction word.
    typedef struct packed
    {
        logic [3:0] op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
    } instr_t;

    function automatic logic op_legal(logic [3:0] code);
        return code <= OP_DIV;
    endfunction

endpackage

// ==== tomasulo_bus_pkg.sv ====
package tomasulo_bus_pkg;

    import tomasulo_isa_pkg::*;

    // Sized for at most eight ROB entries.
    typedef logic [2:0] rob_tag_t;

    typedef struct packed
    {
        logic     valid;
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } issue_req_t;

    // Either a value or the tag of its producer.
    typedef struct packed
    {
        logic     ready;
        data_t    value;
        rob_tag_t tag;
    } operand_t;

    typedef struct packed
    {
        logic     valid;
        op_e      op;
        rob_tag_t dest;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef struct packed
    {
        logic     valid;
        op_e      op;
        data_t    a;
        data_t    b;
        rob_tag_t dest;
    } exec_req_t;

    typedef struct packed
    {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_t;

endpackage

// ==== apb_issue_port.sv ====
`timescale 1ns/100ps

module apb_issue_port
    import tomasulo_isa_pkg::*;
    import tomasulo_bus_pkg::*;
(
    input  logic        clk2,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output issue_req_t  issue,
    input  logic        issue_ready,
    output logic        reg_wr_en,
    output reg_idx_t    reg_wr_idx,
    output data_t       reg_wr_data,
    input  data_t       reg_rd_data,
    input  logic [15:0] status,
    input  logic        idle
);

    localparam logic [7:0] ADDR_INSTR  = 8'h00;
    localparam logic [7:0] ADDR_STATUS = 8'h04;

    logic        setup;
    logic        access;
    logic        hit_instr;
    logic        hit_status;
    logic        hit_reg;
    logic        legal_op;
    instr_t      instr;
    logic [15:0] read_q;

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign instr  = instr_t'(pwdata);

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign hit_instr  = (paddr == ADDR_INSTR) && pwrite;
    assign hit_status = (paddr == ADDR_STATUS) && !pwrite;
    assign hit_reg    = (paddr[7:6] == 2'b01) && (paddr[1:0] == 2'b00);
    assign legal_op   = op_legal(instr.op);

    assign issue.valid = access && hit_instr && legal_op;
    assign issue.op    = op_e'(instr.op);
    assign issue.rd    = instr.rd;
    assign issue.rs1   = instr.rs1;
    assign issue.rs2   = instr.rs2;

    assign reg_wr_idx  = paddr[5:2];
    assign reg_wr_data = pwdata;
    assign reg_wr_en   = access && hit_reg && pwrite && idle;

    // Wait states.
    always_comb
    begin
        if (hit_instr && legal_op)
            pready = issue_ready;
        else if (hit_reg && pwrite)
            pready = idle;
        else
            pready = 1'b1;
    end

    assign pslverr = access && pready && !(hit_status || hit_reg || (hit_instr && legal_op));

    // Read data is sampled in the setup phase.
    always_ff @(posedge clk2 or negedge rst_n)
    begin
        if (!rst_n)
            read_q <= '0;
        else if (setup)
            read_q <= hit_status ? status : reg_rd_data;
    end

    assign prdata = read_q;

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer
    import tomasulo_isa_pkg::*;
    import tomasulo_bus_pkg::*;
#(
    parameter int ROB_DEPTH = 8
)(
    input  logic        clk2,
    input  logic        rst_n,
    input  issue_req_t  issue,
    output logic        issue_ready,
    input  logic        reg_wr_en,
    input  reg_idx_t    reg_wr_idx,
    input  data_t       reg_wr_data,
    output data_t       reg_rd_data,
    output logic [15:0] status,
    output logic        idle,
    input  logic        alu_rs_full,
    input  logic        mul_rs_full,
    input  logic        alu_rs_empty,
    input  logic        mul_rs_empty,
    output rs_entry_t   rs_alloc,
    output logic        rs_alloc_mul,
    output logic        rs_alloc_alu,
    input  cdb_t        alu_result,
    input  cdb_t        mul_result,
    output logic        alu_grant,
    output logic        mul_grant,
    output cdb_t        cdb
);

    reg_idx_t   rob_rd    [ROB_DEPTH];
    data_t      rob_value [ROB_DEPTH];
    logic       rob_done  [ROB_DEPTH];
    rob_tag_t   head;
    rob_tag_t   tail;
    logic [3:0] count;

    data_t      regs      [2**REG_W];
    logic       reg_busy  [2**REG_W];
    rob_tag_t   reg_tag   [2**REG_W];

    logic       is_mul;
    logic       do_issue;
    logic       do_commit;
    reg_idx_t   commit_rd;

    function automatic rob_tag_t next_ptr(rob_tag_t p);
        return (p == rob_tag_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Register file, then a finished ROB entry, then the CDB.
    function automatic operand_t read_operand(reg_idx_t r);
        operand_t opnd;
        rob_tag_t t;
        t          = reg_tag[r];
        opnd.tag   = t;
        opnd.ready = 1'b1;
        opnd.value = regs[r];
        if (reg_busy[r])
        begin
            if (rob_done[t])
                opnd.value = rob_value[t];
            else if (cdb.valid && cdb.tag == t)
                opnd.value = cdb.value;
            else
                opnd.ready = 1'b0;
        end
        return opnd;
    endfunction

    // ----------------------------------------
    // Issue and rename
    // ----------------------------------------
    assign is_mul      = issue.op inside {OP_MUL, OP_DIV};
    assign issue_ready = (count < ROB_DEPTH) && !(is_mul ? mul_rs_full : alu_rs_full);
    assign do_issue    = issue.valid && issue_ready;

    always_comb
    begin
        rs_alloc.valid = do_issue;
        rs_alloc.op    = issue.op;
        rs_alloc.dest  = tail;
        rs_alloc.src1  = read_operand(issue.rs1);
        rs_alloc.src2  = read_operand(issue.rs2);
    end

    assign rs_alloc_mul = do_issue && is_mul;
    assign rs_alloc_alu = do_issue && !is_mul;

    // CDB arbitration, multiply/divide first.
    assign mul_grant = mul_result.valid;
    assign alu_grant = alu_result.valid && !mul_result.valid;
    assign cdb       = mul_result.valid ? mul_result : alu_result;

    assign do_commit = (count != '0) && rob_done[head];
    assign commit_rd = rob_rd[head];

    assign reg_rd_data = regs[reg_wr_idx];
    assign idle        = (count == '0) && alu_rs_empty && mul_rs_empty;
    assign status      = {9'd0, count, 2'd0, idle};

    always_ff @(posedge clk2)
    begin
        if (cdb.valid)
        begin
            rob_done[cdb.tag]  <= 1'b1;
            rob_value[cdb.tag] <= cdb.value;
        end
        if (do_issue)
        begin
            rob_rd[tail]       <= issue.rd;
            rob_done[tail]     <= 1'b0;
            reg_tag[issue.rd]  <= tail;
        end
    end

    // ----------------------------------------
    // Pointers, commit, register file
    // ----------------------------------------
    always_ff @(posedge clk2 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int r = 0; r < 2**REG_W; r++)
            begin
                regs[r]     <= '0;
                reg_busy[r] <= 1'b0;
            end
        end
        else
        begin
            if (reg_wr_en)
                regs[reg_wr_idx] <= reg_wr_data;
            if (do_commit)
            begin
                regs[commit_rd] <= rob_value[head];
                // A younger writer keeps the register busy.
                if (reg_tag[commit_rd] == head)
                    reg_busy[commit_rd] <= 1'b0;
                head <= next_ptr(head);
            end
            if (do_issue)
            begin
                reg_busy[issue.rd] <= 1'b1;
                tail               <= next_ptr(tail);
            end
            count <= count + 4'(do_issue) - 4'(do_commit);
        end
    end

endmodule

// ==== reservation_station.sv ====
`timescale 1ns/100ps

module reservation_station
    import tomasulo_bus_pkg::*;
#(
    parameter int RS_DEPTH = 3
)(
    input  logic      clk2,
    input  logic      rst_n,
    input  rs_entry_t alloc,
    input  logic      alloc_en,
    output logic      full,
    input  cdb_t      cdb,
    input  logic      unit_busy,
    output exec_req_t dispatch,
    output logic      empty
);

    localparam int AGE_W = $clog2(RS_DEPTH) + 1;

    // Age counts the younger entries still held.
    rs_entry_t        slot [RS_DEPTH];
    logic [AGE_W-1:0] age  [RS_DEPTH];
    int               pick;
    logic             pick_valid;
    int               free_idx;

    always_comb
    begin
        pick_valid = 1'b0;
        pick       = 0;
        for (int i = 0; i < RS_DEPTH; i++)
        begin
            if (slot[i].valid && slot[i].src1.ready && slot[i].src2.ready &&
                (!pick_valid || age[i] > age[pick]))
            begin
                pick_valid = 1'b1;
                pick       = i;
            end
        end
    end

    always_comb
    begin
        full     = 1'b1;
        empty    = 1'b1;
        free_idx = 0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)
        begin
            if (slot[i].valid)
                empty = 1'b0;
            else
            begin
                full     = 1'b0;
                free_idx = i;
            end
        end
    end

    always_comb
    begin
        dispatch.valid = pick_valid && !unit_busy;
        dispatch.op    = slot[pick].op;
        dispatch.a     = slot[pick].src1.value;
        dispatch.b     = slot[pick].src2.value;
        dispatch.dest  = slot[pick].dest;
    end

    always_ff @(posedge clk2 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < RS_DEPTH; i++)
            begin
                slot[i] <= '0;
                age[i]  <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < RS_DEPTH; i++)
            begin
                if (slot[i].valid)
                begin
                    // Wake up on a matching CDB tag.
                    if (cdb.valid && !slot[i].src1.ready && slot[i].src1.tag == cdb.tag)
                    begin
                        slot[i].src1.ready <= 1'b1;
                        slot[i].src1.value <= cdb.value;
                    end
                    if (cdb.valid && !slot[i].src2.ready && slot[i].src2.tag == cdb.tag)
                    begin
                        slot[i].src2.ready <= 1'b1;
                        slot[i].src2.value <= cdb.value;
                    end
                    age[i] <= age[i] + AGE_W'(alloc_en)
                              - AGE_W'(dispatch.valid && age[i] > age[pick]);
                end
            end
            if (dispatch.valid)
                slot[pick].valid <= 1'b0;
            if (alloc_en)
            begin
                slot[free_idx] <= alloc;
                age[free_idx]  <= '0;
            end
        end
    end

endmodule

// ==== alu_exec.sv ====
`timescale 1ns/100ps

module alu_exec
    import tomasulo_isa_pkg::*;
    import tomasulo_bus_pkg::*;
(
    input  logic      clk2,
    input  logic      rst_n,
    input  exec_req_t req,
    output logic      busy,
    output cdb_t      result,
    input  logic      grant
);

    logic     res_valid;
    rob_tag_t res_tag;
    data_t    res_value;
    data_t    value;

    always_comb
    begin
        case (req.op)
            OP_ADD:  value = req.a + req.b;
            OP_SUB:  value = req.a - req.b;
            OP_AND:  value = req.a & req.b;
            OP_OR:   value = req.a | req.b;
            default: value = '0;
        endcase
    end

    always_ff @(posedge clk2 or negedge rst_n)
    begin
        if (!rst_n)
            res_valid <= 1'b0;
        else if (req.valid)
            res_valid <= 1'b1;
        else if (grant)
            res_valid <= 1'b0;
    end

    always_ff @(posedge clk2)
    begin
        if (req.valid)
        begin
            res_tag   <= req.dest;
            res_value <= value;
        end
    end

    // Free again in the cycle the result is granted.
    assign busy   = res_valid && !grant;
    assign result = '{valid: res_valid, tag: res_tag, value: res_value};

endmodule

// ==== mul_exec.sv ====
`timescale 1ns/100ps

module mul_exec
    import tomasulo_isa_pkg::*;
    import tomasulo_bus_pkg::*;
(
    input  logic      clk2,
    input  logic      rst_n,
    input  exec_req_t req,
    output logic      busy,
    output cdb_t      result,
    input  logic      grant
);

    typedef enum logic [1:0]
    {
        IDLE,
        DIVIDE,
        DONE
    } state_e;

    state_e           state;
    logic [2:0]       step;
    byte_t            quo;
    byte_t            rem;
    byte_t            divisor;
    logic [BYTE_W:0]  rem_shift;
    byte_t            rem_next;
    byte_t            quo_next;
    rob_tag_t         res_tag;
    data_t            res_value;

    // One restoring step. A zero divisor yields 0xFF and the dividend.
    always_comb
    begin
        rem_shift = {rem, quo[BYTE_W-1]};
        if (rem_shift >= {1'b0, divisor})
        begin
            rem_next = byte_t'(rem_shift - {1'b0, divisor});
            quo_next = {quo[BYTE_W-2:0], 1'b1};
        end
        else
        begin
            rem_next = rem_shift[BYTE_W-1:0];
            quo_next = {quo[BYTE_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk2 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            step  <= '0;
        end
        else if (req.valid)
        begin
            state <= (req.op == OP_DIV) ? DIVIDE : DONE;
            step  <= '0;
        end
        else if (state == DIVIDE)
        begin
            step <= step + 1'b1;
            if (step == 3'd7)
                state <= DONE;
        end
        else if (state == DONE && grant)
            state <= IDLE;
    end

    always_ff @(posedge clk2)
    begin
        if (req.valid)
        begin
            res_tag   <= req.dest;
            res_value <= req.a[BYTE_W-1:0] * req.b[BYTE_W-1:0];
            quo       <= req.a[BYTE_W-1:0];
            divisor   <= req.b[BYTE_W-1:0];
            rem       <= '0;
        end
        else if (state == DIVIDE)
        begin
            quo <= quo_next;
            rem <= rem_next;
            if (step == 3'd7)
                res_value <= {rem_next, quo_next};
        end
    end

    assign busy   = (state == DIVIDE) || (state == DONE && !grant);
    assign result = '{valid: state == DONE, tag: res_tag, value: res_value};

endmodule

// ==== tomasulo_core.sv ====
`timescale 1ns/100ps

module tomasulo_core
    import tomasulo_isa_pkg::*;
    import tomasulo_bus_pkg::*;
#(
    parameter int RS_DEPTH  = 3,
    parameter int ROB_DEPTH = 8
)(
    input  logic        clk2,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    issue_req_t  issue;
    logic        issue_ready;
    logic        reg_wr_en;
    reg_idx_t    reg_wr_idx;
    data_t       reg_wr_data;
    data_t       reg_rd_data;
    logic [15:0] status;
    logic        idle;

    rs_entry_t   rs_alloc;
    logic        rs_alloc_alu;
    logic        rs_alloc_mul;
    logic        alu_rs_full;
    logic        mul_rs_full;
    logic        alu_rs_empty;
    logic        mul_rs_empty;

    exec_req_t   alu_req;
    exec_req_t   mul_req;
    logic        alu_busy;
    logic        mul_busy;
    cdb_t        alu_result;
    cdb_t        mul_result;
    logic        alu_grant;
    logic        mul_grant;
    cdb_t        cdb;

    apb_issue_port u_apb_issue_port (
        .clk2        (clk2),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .issue       (issue),
        .issue_ready (issue_ready),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_idx  (reg_wr_idx),
        .reg_wr_data (reg_wr_data),
        .reg_rd_data (reg_rd_data),
        .status      (status),
        .idle        (idle)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_reorder_buffer (
        .clk2         (clk2),
        .rst_n        (rst_n),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_idx   (reg_wr_idx),
        .reg_wr_data  (reg_wr_data),
        .reg_rd_data  (reg_rd_data),
        .status       (status),
        .idle         (idle),
        .alu_rs_full  (alu_rs_full),
        .mul_rs_full  (mul_rs_full),
        .alu_rs_empty (alu_rs_empty),
        .mul_rs_empty (mul_rs_empty),
        .rs_alloc     (rs_alloc),
        .rs_alloc_mul (rs_alloc_mul),
        .rs_alloc_alu (rs_alloc_alu),
        .alu_result   (alu_result),
        .mul_result   (mul_result),
        .alu_grant    (alu_grant),
        .mul_grant    (mul_grant),
        .cdb          (cdb)
    );

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) alu_rs (
        .clk2      (clk2),
        .rst_n     (rst_n),
        .alloc     (rs_alloc),
        .alloc_en  (rs_alloc_alu),
        .full      (alu_rs_full),
        .cdb       (cdb),
        .unit_busy (alu_busy),
        .dispatch  (alu_req),
        .empty     (alu_rs_empty)
    );

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) mul_rs (
        .clk2      (clk2),
        .rst_n     (rst_n),
        .alloc     (rs_alloc),
        .alloc_en  (rs_alloc_mul),
        .full      (mul_rs_full),
        .cdb       (cdb),
        .unit_busy (mul_busy),
        .dispatch  (mul_req),
        .empty     (mul_rs_empty)
    );

    alu_exec u_alu_exec (
        .clk2   (clk2),
        .rst_n  (rst_n),
        .req    (alu_req),
        .busy   (alu_busy),
        .result (alu_result),
        .grant  (alu_grant)
    );

    mul_exec u_mul_exec (
        .clk2   (clk2),
        .rst_n  (rst_n),
        .req    (mul_req),
        .busy   (mul_busy),
        .result (mul_result),
        .grant  (mul_grant)
    );

endmodule

// ==== tb_tomasulo_core.sv ====
`timescale 1ns/100ps

module tb_tomasulo_core
    import tomasulo_isa_pkg::*;
();

    localparam int         MAX_CYCLES  = 20000;
    localparam logic [7:0] ADDR_INSTR  = 8'h00;
    localparam logic [7:0] ADDR_STATUS = 8'h04;

    logic        clk2;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [15:0] model [16];
    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          cycles;

    tomasulo_core u_tomasulo_core (
        .clk2    (clk2),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk2 = 1'b0;
        forever #50 clk2 = ~clk2;
    end

    // Run limit.
    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk2);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles.", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------
    function automatic logic [15:0] model_result(input logic [3:0] op, input logic [15:0] a,
                                                 input logic [15:0] b);
        logic [7:0]  x;
        logic [7:0]  y;
        logic [15:0] r;
        x = a[7:0];
        y = b[7:0];
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_MUL:  r = 16'(x) * 16'(y);
            default: r = (y == 8'd0) ? {x, 8'hFF} : {x % y, x / y};
        endcase
        return r;
    endfunction

    function automatic logic [7:0] reg_addr(input int n);
        return 8'h40 | 8'(n << 2);
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // ----------------------------------------
    // APB access
    // ----------------------------------------
    // Starts 10 ns after an edge and ends 10 ns after the completing edge.
    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err);
        logic done;
        done    = 1'b0;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk2);
        #10;
        penable = 1'b1;
        while (!done)
        begin
            @(negedge clk2);
            done  = pready;
            rdata = prdata;
            err   = pslverr;
            @(posedge clk2);
        end
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_reg(input int n, input logic [15:0] value);
        logic [15:0] rdata;
        logic        err;
        apb_xfer(reg_addr(n), 1'b1, value, rdata, err);
        check_value("register write pslverr", 16'(err), 16'd0);
        model[n] = value;
    endtask

    task automatic issue_op(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs1,
                            input logic [3:0] rs2);
        logic [15:0] rdata;
        logic        err;
        logic        legal;
        legal = (op <= 4'd5);
        apb_xfer(ADDR_INSTR, 1'b1, {op, rd, rs1, rs2}, rdata, err);
        check_value("instruction pslverr", 16'(err), 16'(!legal));
        if (legal)
            model[rd] = model_result(op, model[rs1], model[rs2]);
    endtask

    task automatic wait_idle();
        logic [15:0] st;
        logic        err;
        st = '0;
        while (!st[0])
        begin
            apb_xfer(ADDR_STATUS, 1'b0, 16'd0, st, err);
            check_value("status pslverr", 16'(err), 16'd0);
        end
        // Idle also means an empty ROB.
        check_value("status at idle", st, 16'h0001);
    endtask

    task automatic compare_regs();
        logic [15:0] rdata;
        logic        err;
        for (int n = 0; n < 16; n++)
        begin
            apb_xfer(reg_addr(n), 1'b0, 16'd0, rdata, err);
            check_value($sformatf("r%0d", n), rdata, model[n]);
            check_value("register read pslverr", 16'(err), 16'd0);
        end
    endtask

    task automatic randomize_regs();
        for (int n = 0; n < 16; n++)
            set_reg(n, 16'($random(seed)));
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        $display("test %0d %s finished, %0d errors", tests_run, name, errors - err_before);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial
    begin
        logic [15:0] rdata;
        logic        err;
        int          start;
        seed      = 32'h954e3854;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        for (int n = 0; n < 16; n++)
            model[n] = '0;
        repeat (3) @(posedge clk2);
        #10;
        rst_n = 1'b1;

        start = errors;
        compare_regs();
        randomize_regs();
        compare_regs();
        apb_xfer(8'h08, 1'b0, 16'd0, rdata, err);
        check_value("unmapped read pslverr", 16'(err), 16'd1);
        apb_xfer(8'h41, 1'b1, 16'hBEEF, rdata, err);
        check_value("unmapped write pslverr", 16'(err), 16'd1);
        issue_op(4'h6, 4'd1, 4'd2, 4'd3);
        issue_op(4'hF, 4'd4, 4'd5, 4'd6);
        wait_idle();
        compare_regs();
        end_test("register access", start);

        start = errors;
        set_reg(1, 16'h1234);
        set_reg(2, 16'h0F0F);
        set_reg(3, 16'h0001);
        set_reg(4, 16'h0005);
        issue_op(OP_ADD, 4'd5, 4'd1, 4'd2);
        issue_op(OP_SUB, 4'd6, 4'd3, 4'd4);
        issue_op(OP_AND, 4'd7, 4'd1, 4'd2);
        issue_op(OP_OR, 4'd8, 4'd1, 4'd2);
        wait_idle();
        compare_regs();
        end_test("alu operations", start);

        start = errors;
        set_reg(1, 16'hABFF);
        set_reg(2, 16'h00FF);
        set_reg(3, 16'h7780);
        set_reg(4, 16'h1200);
        set_reg(9, 16'h0007);
        issue_op(OP_MUL, 4'd5, 4'd1, 4'd2);
        issue_op(OP_MUL, 4'd6, 4'd3, 4'd4);
        issue_op(OP_MUL, 4'd7, 4'd3, 4'd1);
        issue_op(OP_DIV, 4'd8, 4'd1, 4'd9);
        issue_op(OP_DIV, 4'd10, 4'd3, 4'd4);
        issue_op(OP_DIV, 4'd11, 4'd4, 4'd1);
        wait_idle();
        compare_regs();
        end_test("multiply and divide", start);

        start = errors;
        randomize_regs();
        issue_op(OP_DIV, 4'd1, 4'd2, 4'd3);
        // One divide in flight, so occupancy 1 and not idle.
        apb_xfer(ADDR_STATUS, 1'b0, 16'd0, rdata, err);
        check_value("status with one divide in flight", rdata, 16'h0008);
        issue_op(OP_ADD, 4'd4, 4'd1, 4'd5);
        issue_op(OP_MUL, 4'd6, 4'd4, 4'd7);
        // WAR on r5 and WAW on r1.
        issue_op(OP_SUB, 4'd5, 4'd8, 4'd9);
        issue_op(OP_OR, 4'd1, 4'd10, 4'd11);
        issue_op(OP_ADD, 4'd12, 4'd1, 4'd4);
        wait_idle();
        compare_regs();
        end_test("dependencies", start);

        start = errors;
        randomize_regs();
        for (int i = 0; i < 12; i++)
            issue_op(OP_DIV, 4'((i + 4) % 16), 4'(i), 4'((i + 1) % 16));
        // Independent adds finish early and pile up behind the divides until the ROB is full.
        for (int i = 0; i < 8; i++)
            issue_op(OP_ADD, 4'd0, 4'd0, 4'd1);
        wait_idle();
        compare_regs();
        end_test("back-pressure", start);

        start = errors;
        randomize_regs();
        for (int i = 0; i < 40; i++)
            issue_op(4'($unsigned($random(seed)) % 6), 4'($random(seed)),
                     4'($random(seed)), 4'($random(seed)));
        wait_idle();
        compare_regs();
        end_test("random program", start);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== tomasulo_core.f ====
tomasulo_isa_pkg.sv
tomasulo_bus_pkg.sv
apb_issue_port.sv
reorder_buffer.sv
reservation_station.sv
alu_exec.sv
mul_exec.sv
tomasulo_core.sv
tb_tomasulo_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tomasulo_core.f \
    --top-module tb_tomasulo_core \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
